/* core_config.svh */
// global sizing macros for the core; XLEN and NUM_REGS are assumed to stay 32 as port widths depend on it
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ----------------------------------------------------------------------
// datapath sizing
// ----------------------------------------------------------------------

// width of registers, ALU and data memory words
`define XLEN		32

// architectural registers incl. hard-wired x0
`define NUM_REGS	32

// ----------------------------------------------------------------------
// data memory
// ----------------------------------------------------------------------

// word count of stage-4 data memory, must be a power of two
`define DMEM_WORDS	64

`endif

/* core_pkg.sv */
// shared enums only; encodings for fetch and branch ops are not part of this core
package core_pkg;

	// ----------------------------------------------------------------------
	// operation encodings
	// ----------------------------------------------------------------------

	// ENC_NONE doubles as the idle slot and the stall bubble
	typedef enum logic [3:0] {
		ENC_NONE		= 4'd0,	// no operation
		ENC_LUI			= 4'd1,	// rd <= imm, no source regs
		ENC_ARITH		= 4'd2,	// rd <= rs1 op rs2
		ENC_ARITH_IMM	= 4'd3,	// rd <= rs1 op imm
		ENC_LOAD		= 4'd4,	// rd <= mem[rs1 + imm]
		ENC_STORE		= 4'd5	// mem[rs1 + imm] <= rs2
	} op_enc_e;

	// ----------------------------------------------------------------------
	// alu functions
	// ----------------------------------------------------------------------

	typedef enum logic [2:0] {
		ALU_ADD	= 3'd0,
		ALU_SUB	= 3'd1,
		ALU_AND	= 3'd2,
		ALU_OR	= 3'd3,
		ALU_XOR	= 3'd4,
		ALU_SLT	= 3'd5,	// signed compare, result is 0 or 1
		ALU_SLL	= 3'd6,	// shift amount from low 5 bits
		ALU_SRL	= 3'd7	// logical, zero fill
	} alu_op_e;

endpackage

/* core_trace.txt */
# I enc alu rs1 rs2 rd imm(hex)  enc 1 lui 2 arith 3 arith_imm 4 load 5 store
# W rd data(hex)                 alu 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 sll 7 srl
I 1 0 0 0 1 00001000
W 1 00001000
I 3 0 1 0 2 00000234
W 2 00001234
I 2 1 2 1 3 00000000
W 3 00000234
I 2 2 2 3 4 00000000
W 4 00000234
I 2 3 1 3 5 00000000
W 5 00001234
I 2 4 5 2 0 00000000
I 2 0 0 4 6 00000000
W 6 00000234
I 3 5 0 0 7 00000001
W 7 00000001
I 3 6 7 0 8 0000001f
W 8 80000000
I 3 7 8 0 8 00000024
W 8 08000000
I 3 0 8 0 9 00000001
W 9 08000001
I 5 0 0 9 0 00000010
I 4 0 0 0 10 00000010
W 10 08000001
I 2 0 10 1 11 00000000
W 11 08001001
I 4 0 0 0 12 00000010
W 12 08000001
I 3 0 1 12 13 00000001
W 13 00001001
I 4 0 0 0 14 00000010
W 14 08000001
I 5 0 0 14 0 00000020
I 4 0 0 0 15 00000020
W 15 08000001

/* dependency_handler.sv */
// purely combinational; a load in stage 3 is never forwarded and only raises the stall flag
`include "core_config.svh"

module dependency_handler
	import core_pkg::*;
(
	input	op_enc_e							enc_i,			// op at the issue port
	input	op_enc_e							s3_enc_i,
	input	op_enc_e							s4_enc_i,
	input	logic	[`NUM_REGS*`XLEN-1:0]		rf_vec_i,		// flat register file
	input	logic	[$clog2(`NUM_REGS)-1:0]		src1_i,
	input	logic	[$clog2(`NUM_REGS)-1:0]		src2_i,
	input	logic	[$clog2(`NUM_REGS)-1:0]		s3_rd_i,		// dest of op in execute
	input	logic	[$clog2(`NUM_REGS)-1:0]		s4_rd_i,		// dest of op in memory stage
	input	logic	[`XLEN-1:0]					s3_data_i,
	input	logic	[`XLEN-1:0]					s4_data_i,
	output	logic								stall_o,		// load-use hazard on either source
	output	logic	[`XLEN-1:0]					src1_operand_o,
	output	logic	[`XLEN-1:0]					src2_operand_o
);

logic	src1_stall;
logic	src2_stall;

assign stall_o = src1_stall | src2_stall;

// ----------------------------------------------------------------------
// one checker per source operand
// ----------------------------------------------------------------------

src_dependency_handler #(
	.SRC			(1)
) i_src1_dep (
	.enc_i			(enc_i),
	.s3_enc_i		(s3_enc_i),
	.s4_enc_i		(s4_enc_i),
	.rf_vec_i		(rf_vec_i),
	.src_i			(src1_i),
	.s3_rd_i		(s3_rd_i),
	.s4_rd_i		(s4_rd_i),
	.s3_data_i		(s3_data_i),
	.s4_data_i		(s4_data_i),
	.stall_o		(src1_stall),
	.src_operand_o	(src1_operand_o)
);

src_dependency_handler #(
	.SRC			(2)
) i_src2_dep (
	.enc_i			(enc_i),
	.s3_enc_i		(s3_enc_i),
	.s4_enc_i		(s4_enc_i),
	.rf_vec_i		(rf_vec_i),
	.src_i			(src2_i),
	.s3_rd_i		(s3_rd_i),
	.s4_rd_i		(s4_rd_i),
	.s3_data_i		(s3_data_i),
	.s4_data_i		(s4_data_i),
	.stall_o		(src2_stall),
	.src_operand_o	(src2_operand_o)
);

endmodule

// ----------------------------------------------------------------------
// per-source forwarding and stall decision
// ----------------------------------------------------------------------

module src_dependency_handler
	import core_pkg::*;
#(
	parameter int SRC = 1	// 1 selects rs1 rules, 2 selects rs2 rules
) (
	input	op_enc_e							enc_i,
	input	op_enc_e							s3_enc_i,
	input	op_enc_e							s4_enc_i,
	input	logic	[`NUM_REGS*`XLEN-1:0]		rf_vec_i,
	input	logic	[$clog2(`NUM_REGS)-1:0]		src_i,
	input	logic	[$clog2(`NUM_REGS)-1:0]		s3_rd_i,
	input	logic	[$clog2(`NUM_REGS)-1:0]		s4_rd_i,
	input	logic	[`XLEN-1:0]					s3_data_i,
	input	logic	[`XLEN-1:0]					s4_data_i,
	output	logic								stall_o,
	output	logic	[`XLEN-1:0]					src_operand_o
);

logic	[`XLEN-1:0]	rf	[`NUM_REGS];	// unpacked register view
logic				src_used;			// op really reads this source
logic				s3_has_rd;			// stage 3 op produces a register value
logic				s4_has_rd;

genvar k;
generate
	for (k = 0; k < `NUM_REGS; k++) begin : g_rf_unpack
		assign rf[k] = rf_vec_i[`XLEN*k +: `XLEN];
	end
endgenerate

// stores and bubbles carry no destination
assign s3_has_rd = (s3_enc_i != ENC_NONE) && (s3_enc_i != ENC_STORE);
assign s4_has_rd = (s4_enc_i != ENC_NONE) && (s4_enc_i != ENC_STORE);

always_comb begin
	src_used = 1'b1;
	if (src_i == '0)															src_used = 1'b0;
	else if (enc_i == ENC_NONE)													src_used = 1'b0;
	else if (enc_i == ENC_LUI)													src_used = 1'b0;	// no sources
	else if ((SRC == 2) && (enc_i == ENC_ARITH_IMM || enc_i == ENC_LOAD))		src_used = 1'b0;	// imm form
end

always_comb begin
	stall_o			= 1'b0;
	src_operand_o	= rf[src_i];	// default straight from register file
	if (src_used) begin
		// older result first, stage 3 overrides below
		if ((src_i == s4_rd_i) && s4_has_rd) begin
			src_operand_o = s4_data_i;
		end
		if ((src_i == s3_rd_i) && s3_has_rd) begin
			if (s3_enc_i == ENC_LOAD) begin
				stall_o = 1'b1;				// load data only exists in stage 4
			end else begin
				src_operand_o = s3_data_i;
			end
		end
	end
end

endmodule

/* execute_unit.sv */
// one register stage in front of the ALU; a stall turns the captured op into a bubble
`include "core_config.svh"

module execute_unit
	import core_pkg::*;
(
	input	logic								clk_i,
	input	logic								rst_n_i,
	input	op_enc_e							enc_i,
	input	alu_op_e							alu_i,
	input	logic	[$clog2(`NUM_REGS)-1:0]		rd_i,
	input	logic	[`XLEN-1:0]					imm_i,
	input	logic	[`XLEN-1:0]					op1_i,		// forwarded rs1 value
	input	logic	[`XLEN-1:0]					op2_i,		// forwarded rs2 value
	input	logic								stall_i,	// load-use, drop the issue op
	output	op_enc_e							s3_enc_o,
	output	logic	[$clog2(`NUM_REGS)-1:0]		s3_rd_o,
	output	logic	[`XLEN-1:0]					s3_result_o,	// alu result or mem address
	output	logic	[`XLEN-1:0]					s3_store_data_o
);

alu_op_e			alu_q;
logic	[`XLEN-1:0]	imm_q;
logic	[`XLEN-1:0]	op1_q;
logic	[`XLEN-1:0]	op2_q;
logic	[`XLEN-1:0]	alu_b;		// second alu operand
logic	[`XLEN-1:0]	alu_res;

// ----------------------------------------------------------------------
// stage 3 registers
// ----------------------------------------------------------------------

always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		s3_enc_o <= ENC_NONE;
	end else begin
		s3_enc_o <= stall_i ? ENC_NONE : enc_i;	// bubble while stalled
	end
end

// payload follows the issue port every cycle
always_ff @(posedge clk_i) begin
	alu_q	<= alu_i;
	s3_rd_o	<= rd_i;
	imm_q	<= imm_i;
	op1_q	<= op1_i;
	op2_q	<= op2_i;
end

// ----------------------------------------------------------------------
// alu
// ----------------------------------------------------------------------

assign alu_b = (s3_enc_o == ENC_ARITH_IMM) ? imm_q : op2_q;

always_comb begin
	case (alu_q)
		ALU_ADD:	alu_res = op1_q + alu_b;
		ALU_SUB:	alu_res = op1_q - alu_b;
		ALU_AND:	alu_res = op1_q & alu_b;
		ALU_OR:		alu_res = op1_q | alu_b;
		ALU_XOR:	alu_res = op1_q ^ alu_b;
		ALU_SLT:	alu_res = {{(`XLEN-1){1'b0}}, ($signed(op1_q) < $signed(alu_b))};
		ALU_SLL:	alu_res = op1_q << alu_b[4:0];
		ALU_SRL:	alu_res = op1_q >> alu_b[4:0];
		default:	alu_res = '0;
	endcase
end

// result mux per encoding
always_comb begin
	case (s3_enc_o)
		ENC_LUI:					s3_result_o = imm_q;
		ENC_ARITH, ENC_ARITH_IMM:	s3_result_o = alu_res;
		ENC_LOAD, ENC_STORE:		s3_result_o = op1_q + imm_q;	// effective address
		default:					s3_result_o = '0;
	endcase
end

assign s3_store_data_o = op2_q;	// rs2 for stores

endmodule

/* hazard_pipeline_core.sv */
// takes pre-decoded ops only; issue source must hold its op while issue_ready_o is low and writebacks are never back-pressured
`include "core_config.svh"

module hazard_pipeline_core
	import core_pkg::*;
(
	input	logic								clk_i,
	input	logic								rst_n_i,
	// issue port
	input	op_enc_e							issue_enc_i,	// ENC_NONE is an idle slot
	input	alu_op_e							issue_alu_i,
	input	logic	[$clog2(`NUM_REGS)-1:0]		issue_rs1_i,
	input	logic	[$clog2(`NUM_REGS)-1:0]		issue_rs2_i,
	input	logic	[$clog2(`NUM_REGS)-1:0]		issue_rd_i,
	input	logic	[`XLEN-1:0]					issue_imm_i,
	output	logic								issue_ready_o,
	// writeback port
	output	logic								wb_valid_o,
	output	logic	[$clog2(`NUM_REGS)-1:0]		wb_rd_o,
	output	logic	[`XLEN-1:0]					wb_data_o
);

// ----------------------------------------------------------------------
// internal nets
// ----------------------------------------------------------------------

logic	[`NUM_REGS*`XLEN-1:0]		rf_vec;
logic								stall;
logic	[`XLEN-1:0]					op1;			// resolved rs1
logic	[`XLEN-1:0]					op2;			// resolved rs2
op_enc_e							s3_enc;
logic	[$clog2(`NUM_REGS)-1:0]		s3_rd;
logic	[`XLEN-1:0]					s3_result;
logic	[`XLEN-1:0]					s3_store_data;
op_enc_e							s4_enc;
logic	[$clog2(`NUM_REGS)-1:0]		s4_rd;
logic	[`XLEN-1:0]					s4_data;

assign issue_ready_o = ~stall;

// ----------------------------------------------------------------------
// issue / operand stage
// ----------------------------------------------------------------------

register_file i_rf (
	.clk_i		(clk_i),
	.rst_n_i	(rst_n_i),
	.we_i		(wb_valid_o),	// written one edge after stage 4
	.waddr_i	(wb_rd_o),
	.wdata_i	(wb_data_o),
	.rf_vec_o	(rf_vec)
);

dependency_handler i_dep (
	.enc_i			(issue_enc_i),
	.s3_enc_i		(s3_enc),
	.s4_enc_i		(s4_enc),
	.rf_vec_i		(rf_vec),
	.src1_i			(issue_rs1_i),
	.src2_i			(issue_rs2_i),
	.s3_rd_i		(s3_rd),
	.s4_rd_i		(s4_rd),
	.s3_data_i		(s3_result),
	.s4_data_i		(s4_data),
	.stall_o		(stall),
	.src1_operand_o	(op1),
	.src2_operand_o	(op2)
);

// ----------------------------------------------------------------------
// execute and memory stages
// ----------------------------------------------------------------------

execute_unit i_ex (
	.clk_i				(clk_i),
	.rst_n_i			(rst_n_i),
	.enc_i				(issue_enc_i),
	.alu_i				(issue_alu_i),
	.rd_i				(issue_rd_i),
	.imm_i				(issue_imm_i),
	.op1_i				(op1),
	.op2_i				(op2),
	.stall_i			(stall),
	.s3_enc_o			(s3_enc),
	.s3_rd_o			(s3_rd),
	.s3_result_o		(s3_result),
	.s3_store_data_o	(s3_store_data)
);

memory_stage i_mem (
	.clk_i				(clk_i),
	.rst_n_i			(rst_n_i),
	.s3_enc_i			(s3_enc),
	.s3_rd_i			(s3_rd),
	.s3_result_i		(s3_result),
	.s3_store_data_i	(s3_store_data),
	.s4_enc_o			(s4_enc),
	.s4_rd_o			(s4_rd),
	.s4_data_o			(s4_data),
	.wb_valid_o			(wb_valid_o),
	.wb_rd_o			(wb_rd_o),
	.wb_data_o			(wb_data_o)
);

endmodule

/* memory_stage.sv */
// word-addressed data memory using address bits above the byte offset; upper address bits are ignored
`include "core_config.svh"

module memory_stage
	import core_pkg::*;
(
	input	logic								clk_i,
	input	logic								rst_n_i,
	input	op_enc_e							s3_enc_i,
	input	logic	[$clog2(`NUM_REGS)-1:0]		s3_rd_i,
	input	logic	[`XLEN-1:0]					s3_result_i,		// alu result or address
	input	logic	[`XLEN-1:0]					s3_store_data_i,
	output	op_enc_e							s4_enc_o,
	output	logic	[$clog2(`NUM_REGS)-1:0]		s4_rd_o,
	output	logic	[`XLEN-1:0]					s4_data_o,			// load word or held result
	output	logic								wb_valid_o,
	output	logic	[$clog2(`NUM_REGS)-1:0]		wb_rd_o,
	output	logic	[`XLEN-1:0]					wb_data_o
);

localparam int MEM_AW = $clog2(`DMEM_WORDS);

logic	[`XLEN-1:0]		dmem	[`DMEM_WORDS];
logic	[`XLEN-1:0]		s4_result_q;
logic	[MEM_AW-1:0]	st_addr;		// store address from stage 3
logic	[MEM_AW-1:0]	ld_addr;		// load address held in stage 4

assign st_addr = s3_result_i[MEM_AW+1:2];
assign ld_addr = s4_result_q[MEM_AW+1:2];

// ----------------------------------------------------------------------
// data memory, written as the store leaves stage 3
// ----------------------------------------------------------------------

always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		for (int i = 0; i < `DMEM_WORDS; i++) begin
			dmem[i] <= '0;
		end
	end else if (s3_enc_i == ENC_STORE) begin
		dmem[st_addr] <= s3_store_data_i;
	end
end

// ----------------------------------------------------------------------
// stage 4 registers
// ----------------------------------------------------------------------

always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) s4_enc_o <= ENC_NONE;
	else          s4_enc_o <= s3_enc_i;
end

always_ff @(posedge clk_i) begin
	s4_rd_o		<= s3_rd_i;
	s4_result_q	<= s3_result_i;
end

assign s4_data_o = (s4_enc_o == ENC_LOAD) ? dmem[ld_addr] : s4_result_q;

// writeback only for ops with a real destination
assign wb_valid_o	= ((s4_enc_o == ENC_LUI) || (s4_enc_o == ENC_ARITH) ||
					   (s4_enc_o == ENC_ARITH_IMM) || (s4_enc_o == ENC_LOAD)) &&
					  (s4_rd_o != '0);
assign wb_rd_o		= s4_rd_o;
assign wb_data_o	= s4_data_o;

endmodule

/* register_file.sv */
// single write port, no read ports; the whole file leaves as one flat vector with x0 in the lowest word
`include "core_config.svh"

module register_file (
	input	logic								clk_i,
	input	logic								rst_n_i,
	input	logic								we_i,		// write strobe from writeback
	input	logic	[$clog2(`NUM_REGS)-1:0]		waddr_i,
	input	logic	[`XLEN-1:0]					wdata_i,
	output	logic	[`NUM_REGS*`XLEN-1:0]		rf_vec_o	// reg k at bits 32*k+31:32*k
);

// ----------------------------------------------------------------------
// storage
// ----------------------------------------------------------------------

// x0 has no storage at all
logic	[`XLEN-1:0]	regs	[1:`NUM_REGS-1];

always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		for (int i = 1; i < `NUM_REGS; i++) begin
			regs[i] <= '0;
		end
	end else if (we_i && (waddr_i != '0)) begin	// writes to x0 dropped
		regs[waddr_i] <= wdata_i;
	end
end

// ----------------------------------------------------------------------
// flatten onto the output vector
// ----------------------------------------------------------------------

assign rf_vec_o[`XLEN-1:0] = '0;	// x0 reads as zero

genvar k;
generate
	for (k = 1; k < `NUM_REGS; k++) begin : g_rf_pack
		assign rf_vec_o[`XLEN*k +: `XLEN] = regs[k];
	end
endgenerate

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the core testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_core -f sources.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_core
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation completed"
exit 0

/* sources.f */
+incdir+.
core_pkg.sv
register_file.sv
dependency_handler.sv
execute_unit.sv
memory_stage.sv
hazard_pipeline_core.sv
tb_core.sv

/* tb_core.sv */
// reads core_trace.txt from the project root; assumes the trace lists writebacks in issue order
`include "core_config.svh"

module tb_core
	import core_pkg::*;
();

localparam int CLK_PERIOD = 40;

logic				clk;
logic				rst_n;
op_enc_e			issue_enc;
alu_op_e			issue_alu;
logic	[4:0]		issue_rs1;
logic	[4:0]		issue_rs2;
logic	[4:0]		issue_rd;
logic	[`XLEN-1:0]	issue_imm;
logic				issue_ready;
logic				wb_valid;
logic	[4:0]		wb_rd;
logic	[`XLEN-1:0]	wb_data;

// issue records, one entry per I line
logic	[3:0]		tr_enc	[$];
logic	[2:0]		tr_alu	[$];
logic	[4:0]		tr_rs1	[$];
logic	[4:0]		tr_rs2	[$];
logic	[4:0]		tr_rd	[$];
logic	[`XLEN-1:0]	tr_imm	[$];
logic	[4:0]		exp_rd	[$];	// expected writebacks, oldest first
logic	[`XLEN-1:0]	exp_data	[$];

logic	[31:0]		lcg_state;
int					cycle_count = 0;
int					cycle_limit = 0;

hazard_pipeline_core i_dut (
	.clk_i			(clk),
	.rst_n_i		(rst_n),
	.issue_enc_i	(issue_enc),
	.issue_alu_i	(issue_alu),
	.issue_rs1_i	(issue_rs1),
	.issue_rs2_i	(issue_rs2),
	.issue_rd_i		(issue_rd),
	.issue_imm_i	(issue_imm),
	.issue_ready_o	(issue_ready),
	.wb_valid_o		(wb_valid),
	.wb_rd_o		(wb_rd),
	.wb_data_o		(wb_data)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD/2) clk = ~clk;
end

// ----------------------------------------------------------------------
// helpers
// ----------------------------------------------------------------------

function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1103515245 + 32'd12345;
endfunction

task automatic abort_run(input string msg);
	$display("%s", msg);
	$display("=== FAIL ===");
	$fatal(1, "run aborted");
endtask

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
	if (got !== exp) begin
		$display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
		$display("=== FAIL ===");
		$fatal(1, "value mismatch");
	end
endtask

// does the op at idx really read register r (per encoding)
function automatic logic reads_reg(input int idx, input logic [4:0] r);
	logic	[3:0]	e;
	logic			use1;
	logic			use2;
	e		= tr_enc[idx];
	use1	= (e != ENC_NONE) && (e != ENC_LUI);
	use2	= (e == ENC_ARITH) || (e == ENC_STORE);	// rs2 is a real source only here
	return (r != 5'd0) && ((use1 && tr_rs1[idx] == r) || (use2 && tr_rs2[idx] == r));
endfunction

// does the op at idx write a destination register
function automatic logic writes_reg(input int idx);
	logic	[3:0]	e;
	e = tr_enc[idx];
	return (e == ENC_LUI) || (e == ENC_ARITH) || (e == ENC_ARITH_IMM) || (e == ENC_LOAD);
endfunction

task automatic read_trace();
	int				fd;
	int				n;
	int				enc;
	int				alu;
	int				rs1;
	int				rs2;
	int				rd;
	logic	[31:0]	val;
	string			line;
	fd = $fopen("core_trace.txt", "r");
	if (fd == 0) begin
		abort_run("cannot open core_trace.txt");
	end else begin
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) == "I") begin
				n = $sscanf(line, "I %d %d %d %d %d %h", enc, alu, rs1, rs2, rd, val);
				if (n != 6) begin
					abort_run({"malformed issue record: ", line});
				end else begin
					tr_enc.push_back(enc[3:0]);
					tr_alu.push_back(alu[2:0]);
					tr_rs1.push_back(rs1[4:0]);
					tr_rs2.push_back(rs2[4:0]);
					tr_rd.push_back(rd[4:0]);
					tr_imm.push_back(val);
				end
			end else if (line.len() > 1 && line.getc(0) == "W") begin
				n = $sscanf(line, "W %d %h", rd, val);
				if (n != 2) begin
					abort_run({"malformed writeback record: ", line});
				end else begin
					exp_rd.push_back(rd[4:0]);
					exp_data.push_back(val);
				end
			end	// comment lines fall through
		end
		$fclose(fd);
	end
endtask

// drives gap idle slots then the op, holding it while the core stalls
task automatic issue_record(input int idx, input int gap, input logic exp_stall);
	int stalls;
	stalls = 0;
	repeat (gap) begin
		@(posedge clk);
		issue_enc <= ENC_NONE;
	end
	@(posedge clk);
	issue_enc <= op_enc_e'(tr_enc[idx]);
	issue_alu <= alu_op_e'(tr_alu[idx]);
	issue_rs1 <= tr_rs1[idx];
	issue_rs2 <= tr_rs2[idx];
	issue_rd  <= tr_rd[idx];
	issue_imm <= tr_imm[idx];
	@(negedge clk);	// ready is settled mid-cycle
	while (!issue_ready) begin
		stalls++;
		@(posedge clk);
		@(negedge clk);
	end
	check_value(32'(stalls), {31'd0, exp_stall}, $sformatf("stall cycles of op %0d", idx));
endtask

// ----------------------------------------------------------------------
// writeback monitor and timeout
// ----------------------------------------------------------------------

always @(negedge clk) begin
	if (rst_n && wb_valid) begin
		if (exp_rd.size() == 0) begin
			abort_run($sformatf("extra writeback to x%0d with no record left", wb_rd));
		end else begin
			check_value({27'd0, wb_rd}, {27'd0, exp_rd[0]}, "writeback rd");
			check_value(wb_data, exp_data[0], $sformatf("writeback data of x%0d", wb_rd));
			void'(exp_rd.pop_front());
			void'(exp_data.pop_front());
		end
	end
end

always @(posedge clk) begin
	if (rst_n) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			abort_run($sformatf("timeout, no end of run after %0d cycles", cycle_limit));
		end
	end
end

// ----------------------------------------------------------------------
// main sequence
// ----------------------------------------------------------------------

initial begin
	int		gap;
	logic	dep_prev;
	logic	exp_stall;
	rst_n		= 1'b0;
	issue_enc	= ENC_ARITH;	// a real op waits at the port during reset
	issue_alu	= ALU_ADD;
	issue_rs1	= 5'd1;
	issue_rs2	= 5'd2;
	issue_rd	= '0;
	issue_imm	= '0;
	lcg_state	= 32'hd8c5;
	read_trace();
	cycle_limit	= 4 * (tr_enc.size() + exp_rd.size()) + 20;
	@(posedge clk);
	@(negedge clk);
	check_value({31'd0, issue_ready}, 32'd1, "issue_ready_o in reset");
	check_value({31'd0, wb_valid}, 32'd0, "wb_valid_o in reset");
	@(posedge clk);
	rst_n		<= 1'b1;
	issue_enc	<= ENC_NONE;
	for (int i = 0; i < tr_enc.size(); i++) begin
		lcg_state = lcg_next(lcg_state);
		dep_prev = (i > 0) && writes_reg(i-1) && reads_reg(i, tr_rd[i-1]);
		// consumers and ops after a load follow with no gap
		// so stage 3 and stage 4 forwarding and the load-use path are always hit
		if (dep_prev || (i > 0 && tr_enc[i-1] == ENC_LOAD)) gap = 0;
		else                                                gap = int'(lcg_state[31:16]) % 3;
		exp_stall = dep_prev && (tr_enc[i-1] == ENC_LOAD);
		issue_record(i, gap, exp_stall);
	end
	@(posedge clk);
	issue_enc <= ENC_NONE;
	while (exp_rd.size() != 0) @(posedge clk);
	repeat (4) @(posedge clk);	// quiet window, monitor flags any extra pulse
	$display("=== PASS ===");
	$finish;
end

endmodule
